// File: lc3b_defines.svh
// LC-3b core parameters
// word width, register count and PC value after reset
// shared by the type package and the RTL modules

`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// data and byte address width
`define LC3B_WORD_WIDTH 16

// general purpose registers R0..R7
`define LC3B_NUM_REGS 8

// first fetch address
`define LC3B_RESET_PC 16'h0000

`endif

// File: lc3b_types.sv
// LC-3b type package
// vector types with a meaning, opcode and ALU encodings,
// and the control word produced in decode
`default_nettype none
`include "lc3b_defines.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_word;
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

    // n, z, p from msb down
    typedef logic [2:0] lc3b_nzp;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_pass,
        alu_add,
        alu_and,
        alu_not
    } lc3b_aluop;

    // the all-zero word is a bubble
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       addr1mux_sel;
        logic [1:0] addr2mux_sel;
        logic       br_op;
        logic       lshf;
        logic       sr2mux_sel;
        logic       dcache_read;
        logic       dcache_write;
        logic [1:0] wbmux_sel;
        logic       load_cc;
        logic       load_reg;
        logic       storemux_sel;
    } lc3b_control_word;

endpackage

`default_nettype wire

// File: regfile_if.sv
// register file interface
// two combinational read ports and one write port
// between the pipeline core and the register file
`default_nettype none

interface regfile_if;

    lc3b_types::lc3b_reg  sr1;
    lc3b_types::lc3b_reg  sr2;
    lc3b_types::lc3b_word sr1_data;
    lc3b_types::lc3b_word sr2_data;
    lc3b_types::lc3b_reg  dest;
    lc3b_types::lc3b_word wdata;
    logic                 load;

    // decode reads, writeback writes
    modport core
    (
        output sr1, sr2, dest, wdata, load,
        input  sr1_data, sr2_data
    );

    modport regfile
    (
        input  sr1, sr2, dest, wdata, load,
        output sr1_data, sr2_data
    );

endinterface

`default_nettype wire

// File: control_rom.sv
// LC-3b decode control ROM
// maps opcode and ir5 to the control word of one instruction
// opcodes outside the supported set decode to a bubble
`default_nettype none

module control_rom
(
    input  wire lc3b_types::lc3b_opcode opcode,
    input  wire logic                   ir5,
    output lc3b_types::lc3b_control_word ctrl
);

    always_comb
    begin
        ctrl.opcode       = opcode;
        ctrl.aluop        = lc3b_types::alu_pass;
        ctrl.addr1mux_sel = 1'b0;
        ctrl.addr2mux_sel = 2'b00;
        ctrl.br_op        = 1'b0;
        ctrl.lshf         = 1'b0;
        ctrl.sr2mux_sel   = 1'b0;
        ctrl.dcache_read  = 1'b0;
        ctrl.dcache_write = 1'b0;
        ctrl.wbmux_sel    = 2'b00;
        ctrl.load_cc      = 1'b0;
        ctrl.load_reg     = 1'b0;
        ctrl.storemux_sel = 1'b0;

        case (opcode)
            lc3b_types::op_add,
            lc3b_types::op_and:
            begin
                ctrl.aluop      = (opcode == lc3b_types::op_add) ? lc3b_types::alu_add
                                                                 : lc3b_types::alu_and;
                ctrl.wbmux_sel  = 2'b11;
                ctrl.load_reg   = 1'b1;
                ctrl.load_cc    = 1'b1;
                // imm5 form
                ctrl.sr2mux_sel = ir5;
            end

            lc3b_types::op_not:
            begin
                ctrl.aluop     = lc3b_types::alu_not;
                ctrl.wbmux_sel = 2'b11;
                ctrl.load_reg  = 1'b1;
                ctrl.load_cc   = 1'b1;
            end

            // base + (offset6 << 1)
            lc3b_types::op_ldr:
            begin
                ctrl.addr1mux_sel = 1'b1;
                ctrl.addr2mux_sel = 2'b01;
                ctrl.lshf         = 1'b1;
                ctrl.dcache_read  = 1'b1;
                ctrl.wbmux_sel    = 2'b01;
                ctrl.load_reg     = 1'b1;
                ctrl.load_cc      = 1'b1;
            end

            lc3b_types::op_str:
            begin
                ctrl.addr1mux_sel = 1'b1;
                ctrl.addr2mux_sel = 2'b01;
                ctrl.lshf         = 1'b1;
                ctrl.storemux_sel = 1'b1;
                ctrl.dcache_write = 1'b1;
            end

            // target is PC + 2 + (offset9 << 1)
            lc3b_types::op_br:
            begin
                ctrl.addr2mux_sel = 2'b10;
                ctrl.lshf         = 1'b1;
                ctrl.br_op        = 1'b1;
            end

            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: regfile.sv
// LC-3b register file
// eight 16-bit registers, two read ports and one write port
// a read of the register being written returns the new value
`default_nettype none
`include "lc3b_defines.svh"

module regfile
(
    input wire logic  clk,
    input wire logic  reset,
    regfile_if.regfile rf
);

    lc3b_types::lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (rf.load)
        begin
            regs[rf.dest] <= rf.wdata;
        end
    end

    // write-through lets writeback and decode share a cycle
    assign rf.sr1_data = (rf.load && rf.dest == rf.sr1) ? rf.wdata : regs[rf.sr1];
    assign rf.sr2_data = (rf.load && rf.dest == rf.sr2) ? rf.wdata : regs[rf.sr2];

endmodule

`default_nettype wire

// File: alu.sv
// LC-3b ALU
// pass, add, bitwise and, bitwise not on two words
`default_nettype none

module alu
(
    input  wire lc3b_types::lc3b_aluop aluop,
    input  wire lc3b_types::lc3b_word  a,
    input  wire lc3b_types::lc3b_word  b,
    output lc3b_types::lc3b_word       f
);

    always_comb
    begin
        case (aluop)
            lc3b_types::alu_add: f = a + b;
            lc3b_types::alu_and: f = a & b;
            lc3b_types::alu_not: f = ~a;
            // pass keeps operand a
            default:             f = a;
        endcase
    end

endmodule

`default_nettype wire

// File: pipeline_core.sv
// LC-3b five-stage pipeline
// fetch, decode with hazard stall, execute with branch resolve,
// data memory access and register writeback
`default_nettype none
`include "lc3b_defines.svh"

module pipeline_core
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    regfile_if.core                   rf,
    output lc3b_types::lc3b_word      imem_addr,
    input  wire lc3b_types::lc3b_word imem_rdata,
    output lc3b_types::lc3b_word      dmem_addr,
    output logic                      dmem_read,
    output logic                      dmem_write,
    output lc3b_types::lc3b_word      dmem_wdata,
    input  wire lc3b_types::lc3b_word dmem_rdata
);

    localparam int w = `LC3B_WORD_WIDTH;
    // byte addressed, one instruction is two bytes
    localparam lc3b_types::lc3b_word pc_step = lc3b_types::lc3b_word'(2);

    // fetch
    lc3b_types::lc3b_word pc;
    lc3b_types::lc3b_word pc_plus2;

    // IF/ID
    logic                 if_id_valid;
    lc3b_types::lc3b_word if_id_ir;
    lc3b_types::lc3b_word if_id_pc;

    // decode
    lc3b_types::lc3b_control_word rom_ctrl;
    lc3b_types::lc3b_control_word id_ctrl;
    lc3b_types::lc3b_reg          id_sr1;
    lc3b_types::lc3b_reg          id_sr2;
    lc3b_types::lc3b_reg          id_dest;
    logic                         id_uses_sr1;
    logic                         id_uses_sr2;
    logic                         ex_raw;
    logic                         mem_raw;
    logic                         cc_busy;
    logic                         stall;

    // ID/EX
    lc3b_types::lc3b_control_word id_ex_ctrl;
    lc3b_types::lc3b_word         id_ex_pc;
    lc3b_types::lc3b_word         id_ex_ir;
    lc3b_types::lc3b_word         id_ex_sr1_data;
    lc3b_types::lc3b_word         id_ex_sr2_data;
    lc3b_types::lc3b_reg          id_ex_dest;

    // execute
    lc3b_types::lc3b_word ex_imm5;
    lc3b_types::lc3b_word ex_offset;
    lc3b_types::lc3b_word ex_addr1;
    lc3b_types::lc3b_word ex_addr2;
    lc3b_types::lc3b_word ex_addr;
    lc3b_types::lc3b_word alu_b;
    lc3b_types::lc3b_word ex_alu;
    lc3b_types::lc3b_nzp  br_mask;
    logic                 br_taken;

    // EX/MEM
    lc3b_types::lc3b_control_word ex_mem_ctrl;
    lc3b_types::lc3b_word         ex_mem_alu;
    lc3b_types::lc3b_word         ex_mem_addr;
    lc3b_types::lc3b_word         ex_mem_wdata;
    lc3b_types::lc3b_reg          ex_mem_dest;

    // MEM/WB
    lc3b_types::lc3b_control_word mem_wb_ctrl;
    lc3b_types::lc3b_word         mem_wb_alu;
    lc3b_types::lc3b_word         mem_wb_rdata;
    lc3b_types::lc3b_reg          mem_wb_dest;

    // writeback and condition codes
    lc3b_types::lc3b_word wb_data;
    lc3b_types::lc3b_nzp  cc;
    lc3b_types::lc3b_nzp  cc_next;

    assign imem_addr = pc;
    assign pc_plus2  = pc + pc_step;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc          <= `LC3B_RESET_PC;
            if_id_valid <= 1'b0;
        end
        else if (br_taken)
        begin
            pc          <= ex_addr;
            if_id_valid <= 1'b0;
        end
        else if (!stall)
        begin
            pc          <= pc_plus2;
            if_id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            if_id_ir <= imem_rdata;
            if_id_pc <= pc_plus2;
        end
    end

    control_rom i_control_rom
    (
        .opcode (lc3b_types::lc3b_opcode'(if_id_ir[15:12])),
        .ir5    (if_id_ir[5]),
        .ctrl   (rom_ctrl)
    );

    assign id_ctrl = if_id_valid ? rom_ctrl : '0;
    assign id_sr1  = if_id_ir[8:6];
    // stores read SR from the dest field
    assign id_sr2  = id_ctrl.storemux_sel ? if_id_ir[11:9] : if_id_ir[2:0];
    assign id_dest = if_id_ir[11:9];

    assign rf.sr1 = id_sr1;
    assign rf.sr2 = id_sr2;

    // BR and bubbles read no register
    assign id_uses_sr1 = (id_ctrl.opcode != lc3b_types::op_br);
    assign id_uses_sr2 = id_ctrl.storemux_sel
                       || (!id_ctrl.sr2mux_sel && (id_ctrl.opcode == lc3b_types::op_add
                                                || id_ctrl.opcode == lc3b_types::op_and));

    assign ex_raw  = id_ex_ctrl.load_reg
                   && ((id_uses_sr1 && id_ex_dest == id_sr1)
                    || (id_uses_sr2 && id_ex_dest == id_sr2));
    assign mem_raw = ex_mem_ctrl.load_reg
                   && ((id_uses_sr1 && ex_mem_dest == id_sr1)
                    || (id_uses_sr2 && ex_mem_dest == id_sr2));
    // a branch waits until older cc writers reach writeback
    assign cc_busy = id_ctrl.br_op && (id_ex_ctrl.load_cc || ex_mem_ctrl.load_cc);
    assign stall   = ex_raw || mem_raw || cc_busy;

    always_ff @(posedge clk)
    begin
        if (reset || br_taken || stall)
        begin
            id_ex_ctrl <= '0;
        end
        else
        begin
            id_ex_ctrl <= id_ctrl;
        end
    end

    always_ff @(posedge clk)
    begin
        id_ex_pc       <= if_id_pc;
        id_ex_ir       <= if_id_ir;
        id_ex_sr1_data <= rf.sr1_data;
        id_ex_sr2_data <= rf.sr2_data;
        id_ex_dest     <= id_dest;
    end

    assign ex_imm5 = {{(w-5){id_ex_ir[4]}}, id_ex_ir[4:0]};
    assign alu_b   = id_ex_ctrl.sr2mux_sel ? ex_imm5 : id_ex_sr2_data;

    alu i_alu
    (
        .aluop (id_ex_ctrl.aluop),
        .a     (id_ex_sr1_data),
        .b     (alu_b),
        .f     (ex_alu)
    );

    always_comb
    begin
        case (id_ex_ctrl.addr2mux_sel)
            2'b01:   ex_offset = {{(w-6){id_ex_ir[5]}}, id_ex_ir[5:0]};
            2'b10:   ex_offset = {{(w-9){id_ex_ir[8]}}, id_ex_ir[8:0]};
            default: ex_offset = '0;
        endcase
    end

    assign ex_addr1 = id_ex_ctrl.addr1mux_sel ? id_ex_sr1_data : id_ex_pc;
    assign ex_addr2 = id_ex_ctrl.lshf ? {ex_offset[w-2:0], 1'b0} : ex_offset;
    assign ex_addr  = ex_addr1 + ex_addr2;

    assign br_mask  = id_ex_ir[11:9];
    assign br_taken = id_ex_ctrl.br_op && ((br_mask & cc) != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_mem_ctrl <= '0;
            mem_wb_ctrl <= '0;
        end
        else
        begin
            ex_mem_ctrl <= id_ex_ctrl;
            mem_wb_ctrl <= ex_mem_ctrl;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_mem_alu   <= ex_alu;
        ex_mem_addr  <= ex_addr;
        ex_mem_wdata <= id_ex_sr2_data;
        ex_mem_dest  <= id_ex_dest;
        mem_wb_alu   <= ex_mem_alu;
        mem_wb_rdata <= dmem_rdata;
        mem_wb_dest  <= ex_mem_dest;
    end

    // memory answers in the same cycle
    assign dmem_addr  = ex_mem_addr;
    assign dmem_read  = ex_mem_ctrl.dcache_read;
    assign dmem_write = ex_mem_ctrl.dcache_write;
    assign dmem_wdata = ex_mem_wdata;

    assign wb_data = (mem_wb_ctrl.wbmux_sel == 2'b01) ? mem_wb_rdata : mem_wb_alu;

    assign rf.dest  = mem_wb_dest;
    assign rf.wdata = wb_data;
    assign rf.load  = mem_wb_ctrl.load_reg;

    always_comb
    begin
        if (wb_data[w-1])
        begin
            cc_next = 3'b100;
        end
        else if (wb_data == '0)
        begin
            cc_next = 3'b010;
        end
        else
        begin
            cc_next = 3'b001;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cc <= '0;
        end
        else if (mem_wb_ctrl.load_cc)
        begin
            cc <= cc_next;
        end
    end

endmodule

`default_nettype wire

// File: lc3b_cpu.sv
// LC-3b CPU top level
// pipeline core and register file joined by the register file interface,
// with instruction and data memory on plain ports
`default_nettype none

module lc3b_cpu
(
    input  wire logic                 clk,
    input  wire logic                 reset,

    // instruction memory
    output lc3b_types::lc3b_word      imem_addr,
    input  wire lc3b_types::lc3b_word imem_rdata,

    // data memory, single-cycle strobes
    output lc3b_types::lc3b_word      dmem_addr,
    output logic                      dmem_read,
    output logic                      dmem_write,
    output lc3b_types::lc3b_word      dmem_wdata,
    input  wire lc3b_types::lc3b_word dmem_rdata
);

    regfile_if rf_bus ();

    regfile i_regfile
    (
        .clk   (clk),
        .reset (reset),
        .rf    (rf_bus.regfile)
    );

    pipeline_core i_core
    (
        .clk        (clk),
        .reset      (reset),
        .rf         (rf_bus.core),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// testbench clock and reset source
// free running clock, reset held high for a fixed number of cycles on request
`default_nettype none

module tb_clock_gen
#(
    parameter int period       = 8,
    parameter int reset_cycles = 10
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
    end

    always
    begin
        #(period / 2) clk = ~clk;
    end

    // call on a falling edge, returns on the falling edge that releases reset
    task automatic apply_reset();
        reset = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
    endtask

endmodule

`default_nettype wire

// File: tb_lc3b_cpu.sv
// testbench for the LC-3b pipelined core
// program and data memory models, a sequential ISA model that predicts
// every load address and store, and assertions on the data port
`default_nettype none
`include "lc3b_defines.svh"

module tb_lc3b_cpu;

    localparam int prog_words = 256;
    localparam int data_words = 256;
    localparam int max_events = 64;
    localparam int wait_limit = 2000;
    localparam int step_limit = 1000;

    localparam logic [3:0] add_op = 4'b0001;
    localparam logic [3:0] and_op = 4'b0101;
    localparam logic [3:0] ldr_op = 4'b0110;
    localparam logic [3:0] str_op = 4'b0111;

    logic                 clk;
    logic                 reset;
    lc3b_types::lc3b_word imem_addr;
    lc3b_types::lc3b_word imem_rdata;
    lc3b_types::lc3b_word dmem_addr;
    logic                 dmem_read;
    logic                 dmem_write;
    lc3b_types::lc3b_word dmem_wdata;
    lc3b_types::lc3b_word dmem_rdata;

    lc3b_types::lc3b_word prog [prog_words];
    lc3b_types::lc3b_word dmem [data_words];
    int                   prog_len;

    // predicted data port traffic, in order
    lc3b_types::lc3b_word exp_store_addr [max_events];
    lc3b_types::lc3b_word exp_store_data [max_events];
    lc3b_types::lc3b_word exp_load_addr [max_events];
    int                   exp_store_count;
    int                   exp_load_count;
    int                   store_count;
    int                   load_count;
    logic                 store_ok;
    logic                 load_ok;

    int          error_count;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;
    int unsigned seed_init;

    tb_clock_gen i_clock
    (
        .clk   (clk),
        .reset (reset)
    );

    lc3b_cpu i_dut
    (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    // both memories answer in the same cycle and are word indexed
    assign imem_rdata = prog[imem_addr[8:1]];
    assign dmem_rdata = dmem[dmem_addr[8:1]];

    always @(negedge clk)
    begin
        if (reset)
        begin
            store_count <= 0;
            load_count  <= 0;
        end
        else
        begin
            if (dmem_write)
            begin
                dmem[dmem_addr[8:1]] = dmem_wdata;
                store_count          <= store_count + 1;
            end
            if (dmem_read)
            begin
                load_count <= load_count + 1;
            end
        end
    end

    always_comb
    begin
        store_ok = (store_count < exp_store_count)
                && (dmem_addr == exp_store_addr[store_count[5:0]])
                && (dmem_wdata == exp_store_data[store_count[5:0]]);
        load_ok  = (load_count < exp_load_count)
                && (dmem_addr == exp_load_addr[load_count[5:0]]);
    end

    store_check: assert property (@(negedge clk) disable iff (reset) dmem_write |-> store_ok)
    else
    begin
        error_count++;
        $display("mismatch at %0t: unexpected store of %h to %h", $time, dmem_wdata, dmem_addr);
    end

    load_check: assert property (@(negedge clk) disable iff (reset) dmem_read |-> load_ok)
    else
    begin
        error_count++;
        $display("mismatch at %0t: unexpected load from %h", $time, dmem_addr);
    end

    quiet_in_reset: assert property (@(negedge clk) reset |-> (!dmem_read && !dmem_write))
    else
    begin
        error_count++;
        $display("mismatch at %0t: data strobe high during reset", $time);
    end

    function automatic lc3b_types::lc3b_word reg_form(input logic [3:0] op, input int dr,
                                                      input int sr1, input int sr2);
        reg_form = {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
    endfunction

    function automatic lc3b_types::lc3b_word imm_form(input logic [3:0] op, input int dr,
                                                      input int sr1, input int imm);
        imm_form = {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic lc3b_types::lc3b_word not_form(input int dr, input int sr);
        not_form = {4'b1001, dr[2:0], sr[2:0], 6'b111111};
    endfunction

    // ldr and str share one layout
    function automatic lc3b_types::lc3b_word mem_form(input logic [3:0] op, input int rd,
                                                      input int base, input int off);
        mem_form = {op, rd[2:0], base[2:0], off[5:0]};
    endfunction

    function automatic lc3b_types::lc3b_word branch_form(input int nzp, input int off);
        branch_form = {4'b0000, nzp[2:0], off[8:0]};
    endfunction

    function automatic lc3b_types::lc3b_word sign_extend(input lc3b_types::lc3b_word value,
                                                         input int bits);
        lc3b_types::lc3b_word mask;
        mask = 16'hffff << bits;
        sign_extend = value[bits-1] ? (value | mask) : (value & ~mask);
    endfunction

    function automatic lc3b_types::lc3b_nzp flags_for(input lc3b_types::lc3b_word value);
        if (value[15])
        begin
            flags_for = 3'b100;
        end
        else if (value == 16'h0000)
        begin
            flags_for = 3'b010;
        end
        else
        begin
            flags_for = 3'b001;
        end
    endfunction

    task automatic append_instr(input lc3b_types::lc3b_word instr);
        prog[prog_len[7:0]] = instr;
        prog_len++;
    endtask

    // zero words are never-taken branches, so empty program space runs as no-ops
    task automatic prepare_memories(input bit random_data);
        for (int i = 0; i < prog_words; i++)
        begin
            prog[i] = 16'h0000;
        end
        for (int i = 0; i < data_words; i++)
        begin
            if (random_data)
            begin
                dmem[i] = lc3b_types::lc3b_word'($urandom);
            end
            else
            begin
                dmem[i] = lc3b_types::lc3b_word'(i * 16'h0123 + 16'h4d21);
            end
        end
        prog_len = 0;
    endtask

    // steps the ISA one instruction at a time
    task automatic predict_program();
        lc3b_types::lc3b_word r [8];
        lc3b_types::lc3b_word mem [data_words];
        lc3b_types::lc3b_word ir;
        lc3b_types::lc3b_word pc;
        lc3b_types::lc3b_word b;
        lc3b_types::lc3b_word addr;
        lc3b_types::lc3b_nzp  cc;
        int                   steps;

        for (int i = 0; i < 8; i++)
        begin
            r[i] = 16'h0000;
        end
        for (int i = 0; i < data_words; i++)
        begin
            mem[i] = dmem[i];
        end
        cc              = 3'b000;
        pc              = `LC3B_RESET_PC;
        steps           = 0;
        exp_store_count = 0;
        exp_load_count  = 0;
        while ((pc < 2 * prog_len) && (steps < step_limit))
        begin
            ir    = prog[pc[8:1]];
            pc    = pc + 16'd2;
            steps = steps + 1;
            case (ir[15:12])
                add_op, and_op:
                begin
                    b = ir[5] ? sign_extend(ir, 5) : r[ir[2:0]];
                    r[ir[11:9]] = (ir[15:12] == add_op) ? r[ir[8:6]] + b : r[ir[8:6]] & b;
                    cc = flags_for(r[ir[11:9]]);
                end
                4'b1001:
                begin
                    r[ir[11:9]] = ~r[ir[8:6]];
                    cc = flags_for(r[ir[11:9]]);
                end
                ldr_op:
                begin
                    addr = r[ir[8:6]] + (sign_extend(ir, 6) << 1);
                    if (exp_load_count < max_events)
                    begin
                        exp_load_addr[exp_load_count] = addr;
                        exp_load_count++;
                    end
                    r[ir[11:9]] = mem[addr[8:1]];
                    cc = flags_for(r[ir[11:9]]);
                end
                str_op:
                begin
                    addr = r[ir[8:6]] + (sign_extend(ir, 6) << 1);
                    if (exp_store_count < max_events)
                    begin
                        exp_store_addr[exp_store_count] = addr;
                        exp_store_data[exp_store_count] = r[ir[11:9]];
                        exp_store_count++;
                    end
                    mem[addr[8:1]] = r[ir[11:9]];
                end
                4'b0000:
                begin
                    if ((ir[11:9] & cc) != 3'b000)
                    begin
                        pc = pc + (sign_extend(ir, 9) << 1);
                    end
                end
                // everything else retires as a no-op
                default:
                begin
                end
            endcase
        end
    endtask

    task automatic run_program(input string name);
        int cycles;
        int errors_before;
        bit passed;

        errors_before = error_count;
        predict_program();
        @(negedge clk);
        i_clock.apply_reset();
        // reset just released and nothing fetched yet
        assert (imem_addr == `LC3B_RESET_PC && dmem_read == 1'b0 && dmem_write == 1'b0)
        else
        begin
            error_count++;
            $display("mismatch at %0t: fetch address %h or data strobes wrong after reset",
                     $time, imem_addr);
        end
        cycles = 0;
        while ((store_count < exp_store_count) && (cycles < wait_limit))
        begin
            @(negedge clk);
            cycles++;
        end
        if (store_count < exp_store_count)
        begin
            $display("test %s timed out with %0d of %0d stores seen",
                     name, store_count, exp_store_count);
            timed_out = 1'b1;
        end
        // fetch well past the end, so the last instruction has retired
        cycles = 0;
        while (!timed_out && (imem_addr < 2 * (prog_len + 8)) && (cycles < wait_limit))
        begin
            @(negedge clk);
            cycles++;
        end
        if (!timed_out && (imem_addr < 2 * (prog_len + 8)))
        begin
            $display("test %s timed out before fetch left the program", name);
            timed_out = 1'b1;
        end
        if (!timed_out)
        begin
            assert (store_count == exp_store_count && load_count == exp_load_count)
            else
            begin
                error_count++;
                $display("mismatch at %0t: %0d stores and %0d loads, expected %0d and %0d",
                         $time, store_count, load_count, exp_store_count, exp_load_count);
            end
        end
        passed = (error_count == errors_before) && !timed_out;
        tests_run++;
        if (!passed)
        begin
            tests_failed++;
        end
        $display("test %-8s %s, %0d stores, %0d loads", name,
                 passed ? "passed" : "failed", exp_store_count, exp_load_count);
    endtask

    task automatic empty_after_reset();
        prepare_memories(1'b0);
        run_program("reset");
    endtask

    // back to back dependencies stall decode
    task automatic arith_stalls();
        prepare_memories(1'b0);
        append_instr(imm_form(and_op, 1, 1, 0));
        append_instr(imm_form(add_op, 1, 1, 7));
        append_instr(imm_form(add_op, 2, 1, -3));
        append_instr(reg_form(add_op, 3, 1, 2));
        append_instr(reg_form(and_op, 4, 3, 1));
        append_instr(imm_form(and_op, 5, 3, 9));
        append_instr(imm_form(add_op, 6, 0, -16));
        append_instr(mem_form(str_op, 3, 0, 0));
        append_instr(mem_form(str_op, 4, 0, 1));
        append_instr(mem_form(str_op, 5, 0, 2));
        append_instr(mem_form(str_op, 6, 0, 3));
        append_instr(reg_form(add_op, 7, 6, 3));
        append_instr(mem_form(str_op, 7, 0, 4));
        run_program("arith");
    endtask

    task automatic branch_flush();
        prepare_memories(1'b0);
        append_instr(not_form(1, 0));
        append_instr(branch_form(3'b100, 1));
        append_instr(mem_form(str_op, 1, 0, 0));
        append_instr(branch_form(3'b010, 1));
        append_instr(mem_form(str_op, 1, 0, 1));
        append_instr(imm_form(add_op, 2, 0, 0));
        append_instr(branch_form(3'b010, 2));
        append_instr(imm_form(add_op, 2, 2, 5));
        append_instr(mem_form(str_op, 2, 0, 2));
        append_instr(mem_form(str_op, 2, 0, 3));
        append_instr(imm_form(add_op, 3, 0, 3));
        append_instr(branch_form(3'b101, 1));
        append_instr(mem_form(str_op, 3, 0, 4));
        append_instr(not_form(4, 3));
        append_instr(branch_form(3'b001, 1));
        append_instr(mem_form(str_op, 4, 0, 5));
        run_program("branch");
    endtask

    task automatic load_use();
        prepare_memories(1'b0);
        append_instr(imm_form(add_op, 1, 0, 8));
        append_instr(mem_form(ldr_op, 2, 1, 3));
        append_instr(imm_form(add_op, 3, 2, 5));
        append_instr(mem_form(str_op, 3, 1, 10));
        append_instr(mem_form(ldr_op, 4, 0, -2));
        append_instr(imm_form(add_op, 5, 4, -1));
        append_instr(mem_form(str_op, 5, 1, 11));
        run_program("load");
    endtask

    // opcodes outside the core's set with nonzero fields
    task automatic unknown_opcodes();
        prepare_memories(1'b0);
        append_instr(imm_form(add_op, 1, 0, 9));
        append_instr(16'h3240);
        append_instr(imm_form(add_op, 2, 1, 1));
        append_instr(16'he5ff);
        append_instr(16'hd283);
        append_instr(mem_form(str_op, 2, 0, 0));
        append_instr(16'h2440);
        append_instr(16'hf025);
        append_instr(16'hb3ff);
        append_instr(16'h4801);
        append_instr(16'hc1c0);
        append_instr(16'h8000);
        append_instr(16'ha5ff);
        append_instr(mem_form(str_op, 1, 0, 1));
        append_instr(mem_form(str_op, 2, 0, 2));
        run_program("unknown");
    endtask

    task automatic random_program();
        int kind;
        int dr;
        int sr1;
        int sr2;

        prepare_memories(1'b1);
        for (int i = 0; i < 40; i++)
        begin
            kind = $urandom % 7;
            dr   = $urandom % 8;
            sr1  = $urandom % 8;
            sr2  = $urandom % 8;
            case (kind)
                0:       append_instr(imm_form(add_op, dr, sr1, int'($urandom)));
                1:       append_instr(reg_form(add_op, dr, sr1, sr2));
                2:       append_instr(imm_form(and_op, dr, sr1, int'($urandom)));
                3:       append_instr(reg_form(and_op, dr, sr1, sr2));
                4:       append_instr(not_form(dr, sr1));
                5:       append_instr(mem_form(ldr_op, dr, sr1, int'($urandom)));
                default: append_instr(mem_form(str_op, dr, sr1, int'($urandom)));
            endcase
            // short forward branches only
            if ($urandom % 6 == 0)
            begin
                append_instr(branch_form(1 + $urandom % 7, 1 + $urandom % 2));
            end
        end
        for (int i = 0; i < 8; i++)
        begin
            append_instr(mem_form(str_op, i, 0, 16 + i));
        end
        run_program("random");
    endtask

    initial
    begin
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        timed_out       = 1'b0;
        exp_store_count = 0;
        exp_load_count  = 0;
        seed_init       = $urandom(32'h79f3);
        prepare_memories(1'b0);

        empty_after_reset();
        if (!timed_out)
        begin
            arith_stalls();
        end
        if (!timed_out)
        begin
            branch_flush();
        end
        if (!timed_out)
        begin
            load_use();
        end
        if (!timed_out)
        begin
            unknown_opcodes();
        end
        if (!timed_out)
        begin
            random_program();
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && !timed_out)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lc3b_pipe.f
+incdir+.
lc3b_types.sv
regfile_if.sv
control_rom.sv
regfile.sv
alu.sv
pipeline_core.sv
lc3b_cpu.sv
tb_clock_gen.sv
tb_lc3b_cpu.sv
